// File: lsu_pkg.sv
package lsu_pkg;

    localparam int SRAM_WORDS = 256;                 // Words in the data memory.
    localparam int SRAM_AW    = 8;                   // Word index, address bits 9..2.

    typedef enum logic [3:0] {
        OP_LB  = 4'd1,                               // Signed byte load.
        OP_LBU = 4'd2,                               // Unsigned byte load.
        OP_LH  = 4'd3,                               // Signed halfword load.
        OP_LHU = 4'd4,                               // Unsigned halfword load.
        OP_LW  = 4'd5,                               // Word load.
        OP_SB  = 4'd6,                               // Byte store.
        OP_SH  = 4'd7,                               // Halfword store.
        OP_SW  = 4'd8                                // Word store.
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e     op;                             // Memory operation.
        logic [31:0] addr;                           // Byte address.
        logic [31:0] wdata;                          // Store data, right aligned.
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;                          // Extended load value.
        logic        error;                          // Misaligned access.
    } lsu_rsp_t;

    typedef struct packed {
        logic               en;                      // Access this cycle.
        logic               we;                      // Write when set.
        logic [SRAM_AW-1:0] index;                   // Word index.
        logic [3:0]         wmask;                   // Byte write enables.
        logic [31:0]        wdata;                   // Lane-placed write data.
    } sram_cmd_t;

    function automatic logic op_is_store(input lsu_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    // Log2 of the access size in bytes.
    function automatic logic [1:0] op_size(input lsu_op_e op);
        case (op)
            OP_LH, OP_LHU, OP_SH: return 2'd1;       // Halfword.
            OP_LW, OP_SW:         return 2'd2;       // Word.
            default:              return 2'd0;       // Byte.
        endcase
    endfunction

endpackage

// File: store_align.sv
`timescale 1ns/1ps
module store_align
    import lsu_pkg::*;
(
    input  lsu_op_e     op,
    input  logic [1:0]  offset,                      // Byte offset in word.
    input  logic [31:0] wdata,                       // Right-aligned store data.
    output logic [31:0] lane_data,
    output logic [3:0]  wmask
);

    logic       is_store;
    logic [1:0] size;

    assign is_store = op_is_store(op);
    assign size     = op_size(op);

    // Replicate so every candidate lane carries the data.
    always_comb begin
        case (size)
            2'd0:    lane_data = {4{wdata[7:0]}};    // Byte in all lanes.
            2'd1:    lane_data = {2{wdata[15:0]}};   // Halfword in both halves.
            default: lane_data = wdata;              // Full word.
        endcase
    end

    // Mask selects only the written bytes.
    always_comb begin
        if (!is_store) begin
            wmask = 4'b0000;                         // Loads never write.
        end else begin
            case (size)
                2'd0:    wmask = 4'b0001 << offset;
                2'd1:    wmask = 4'b0011 << offset;
                default: wmask = 4'b1111;
            endcase
        end
    end

endmodule

// File: load_align.sv
`timescale 1ns/1ps
module load_align
    import lsu_pkg::*;
(
    input  lsu_op_e     op,
    input  logic [1:0]  offset,                      // Byte offset in word.
    input  logic [31:0] word,                        // Raw SRAM word.
    output logic [31:0] value
);

    logic [31:0] shifted;

    assign shifted = word >> {offset, 3'b000};       // Move lane to bit 0.

    always_comb begin
        case (op)
            OP_LB:   value = {{24{shifted[7]}}, shifted[7:0]};
            OP_LBU:  value = {24'h0, shifted[7:0]};
            OP_LH:   value = {{16{shifted[15]}}, shifted[15:0]};
            OP_LHU:  value = {16'h0, shifted[15:0]};
            OP_LW:   value = word;                   // Aligned, no shift needed.
            default: value = 32'h0;                  // Stores return nothing.
        endcase
    end

endmodule

// File: data_sram.sv
`timescale 1ns/1ps
module data_sram
    import lsu_pkg::*;
(
    input  logic        clk,
    input  sram_cmd_t   cmd,
    output logic [31:0] rdata                        // Valid one cycle after read.
);

    logic [31:0] mem [SRAM_WORDS];

    always_ff @(posedge clk) begin
        if (cmd.en && cmd.we) begin
            for (int b = 0; b < 4; b++) begin
                if (cmd.wmask[b]) begin
                    mem[cmd.index][8*b +: 8] <= cmd.wdata[8*b +: 8];  // Masked byte.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.en && !cmd.we) begin
            rdata <= mem[cmd.index];                 // Registered read.
        end
    end

    // Read commands from the controller must carry an empty mask.
    a_read_no_mask: assert property (@(posedge clk)
        (cmd.en && !cmd.we) |-> (cmd.wmask == 4'b0000))
        else $error("read command with nonzero wmask");

endmodule

// File: lsu_ctrl.sv
`timescale 1ns/1ps
module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,                         // Request strobe.
    input  lsu_req_t    req_data,
    input  logic [31:0] st_lane_data,                // From store aligner.
    input  logic [3:0]  st_wmask,
    input  logic [31:0] ld_value,                    // From load aligner.
    output lsu_op_e     cur_op,
    output logic [1:0]  cur_offset,
    output logic [31:0] cur_wdata,
    output sram_cmd_t   sram_cmd,
    output logic        busy,
    output logic        finish,
    output lsu_rsp_t    rsp
);

    typedef enum logic [1:0] {
        IDLE,                                        // Waiting for a request.
        ACCESS,                                      // SRAM command on the bus.
        RESP                                         // Load data returning.
    } state_e;

    state_e   state;
    lsu_req_t req_q;                                 // Latched request.
    logic     misaligned;
    logic     is_store;

    assign busy       = (state != IDLE);
    assign is_store   = op_is_store(req_q.op);
    assign cur_op     = req_q.op;
    assign cur_offset = req_q.addr[1:0];
    assign cur_wdata  = req_q.wdata;

    // Natural alignment by access size.
    always_comb begin
        case (op_size(req_q.op))
            2'd1:    misaligned = req_q.addr[0];
            2'd2:    misaligned = |req_q.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // One command per request, suppressed on error.
    assign sram_cmd = '{
        en:    (state == ACCESS) && !misaligned,
        we:    is_store,
        index: req_q.addr[SRAM_AW+1:2],              // Upper bits wrap.
        wmask: st_wmask,
        wdata: st_lane_data
    };

    always_ff @(posedge clk) begin
        if (!busy && req) begin
            req_q <= req_data;                       // Capture on accept.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            finish <= 1'b0;
            rsp    <= '0;
        end else begin
            finish <= 1'b0;                          // Single-cycle pulse.
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (misaligned || is_store) begin
                        state  <= IDLE;
                        finish <= 1'b1;
                        rsp    <= '{rdata: 32'h0, error: misaligned};
                    end else begin
                        state <= RESP;               // Read word next cycle.
                    end
                end
                RESP: begin
                    state  <= IDLE;
                    finish <= 1'b1;
                    rsp    <= '{rdata: ld_value, error: 1'b0};
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_finish_pulse: assert property (@(posedge clk) disable iff (rst)
        finish |=> !finish)
        else $error("finish held for two cycles");

    // A write only lands on an address aligned to its access size.
    a_misalign_no_write: assert property (@(posedge clk) disable iff (rst)
        (sram_cmd.en && sram_cmd.we) |->
            ((req_q.addr[1:0] & ~(2'b11 << op_size(req_q.op))) == 2'b00))
        else $error("SRAM write issued for a misaligned access");

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
module lsu_top
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,                            // Request strobe.
    input  lsu_req_t req_data,
    output logic     busy,
    output logic     finish,                         // One-cycle done pulse.
    output lsu_rsp_t rsp
);

    lsu_op_e     cur_op;
    logic [1:0]  cur_offset;
    logic [31:0] cur_wdata;
    logic [31:0] st_lane_data;
    logic [3:0]  st_wmask;
    logic [31:0] ld_value;
    logic [31:0] sram_rdata;
    sram_cmd_t   sram_cmd;

    lsu_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_data     (req_data),
        .st_lane_data (st_lane_data),
        .st_wmask     (st_wmask),
        .ld_value     (ld_value),
        .cur_op       (cur_op),
        .cur_offset   (cur_offset),
        .cur_wdata    (cur_wdata),
        .sram_cmd     (sram_cmd),
        .busy         (busy),
        .finish       (finish),
        .rsp          (rsp)
    );

    store_align u_store_align (
        .op        (cur_op),
        .offset    (cur_offset),
        .wdata     (cur_wdata),
        .lane_data (st_lane_data),
        .wmask     (st_wmask)
    );

    load_align u_load_align (
        .op     (cur_op),
        .offset (cur_offset),
        .word   (sram_rdata),
        .value  (ld_value)
    );

    data_sram u_sram (
        .clk   (clk),
        .cmd   (sram_cmd),
        .rdata (sram_rdata)
    );

endmodule

// File: tb_lsu.sv
`timescale 1ns/1ps
module tb_lsu
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD      = 100;                  // ns.
    localparam int MAX_OPS         = 600;                  // Upper bound on accesses issued.
    localparam int OP_CYCLES       = 6;                    // Worst case per access, with setup.
    localparam int WATCHDOG_CYCLES = 10 + MAX_OPS * OP_CYCLES + 500;

    logic        clk;
    logic        rst;
    logic        req;
    lsu_req_t    req_data;
    logic        busy;
    logic        finish;
    lsu_rsp_t    rsp;
    logic [31:0] lfsr;                                     // Random state.
    logic [31:0] ref_mem [SRAM_WORDS];                     // Reference memory model.

    lsu_top uut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .busy     (busy),
        .finish   (finish),
        .rsp      (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR at %0t: watchdog expired, the DUT stopped responding", $time);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Taps 32, 22, 2, 1; one step per bit drawn.
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic bit is_store_op(input lsu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // Halfwords need an even address, words a multiple of four.
    function automatic bit is_misaligned(input lsu_op_e op, input logic [31:0] addr);
        case (op)
            OP_LH, OP_LHU, OP_SH: return addr[0];
            OP_LW, OP_SW:         return addr[1:0] != 2'b00;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_load(input lsu_op_e op, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        int          off;
        w   = ref_mem[addr[9:2]];                          // Upper bits wrap.
        off = int'(addr[1:0]);
        b   = w[8*off +: 8];
        h   = (off < 3) ? w[8*off +: 16] : 16'h0;
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            OP_LW:   return w;
            default: return 32'h0;                         // Stores return zero.
        endcase
    endfunction

    task automatic model_store(input lsu_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata);
        int off;
        off = int'(addr[1:0]);
        case (op)
            OP_SB:   ref_mem[addr[9:2]][8*off +: 8] = wdata[7:0];
            OP_SH:   ref_mem[addr[9:2]][8*off +: 16] = wdata[15:0];
            OP_SW:   ref_mem[addr[9:2]] = wdata;
            default: ;
        endcase
    endtask

    // One request, checked for timing, error, data. Pulse only on loads.
    task automatic access(input lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input bit pulse_busy);
        lsu_req_t    r;
        lsu_req_t    stray;
        bit          err;
        bit          seen;
        logic [31:0] exp_data;
        int          exp_cycles;
        int          k;
        err        = is_misaligned(op, addr);
        exp_data   = err ? 32'h0 : model_load(op, addr);
        exp_cycles = (err || is_store_op(op)) ? 1 : 2;    // Edges after accept to finish.
        r.op       = op;
        r.addr     = addr;
        r.wdata    = wdata;
        stray.op    = OP_SW;                               // Would corrupt memory if taken.
        stray.addr  = addr;
        stray.wdata = ~wdata ^ 32'h0bad_0bad;
        seen       = 1'b0;
        @(posedge clk);
        req      <= 1'b1;
        req_data <= r;
        @(posedge clk);                                    // Accepting edge.
        req <= 1'b0;
        @(negedge clk);
        check("busy", 32'(busy), 32'd1);
        for (k = 1; k <= 8; k++) begin
            @(posedge clk);
            if (pulse_busy && k == 1) begin
                req      <= 1'b1;                          // Strobe while busy.
                req_data <= stray;
            end else begin
                req <= 1'b0;
            end
            @(negedge clk);
            if (finish) begin
                seen = 1'b1;
                break;
            end
            check("busy", 32'(busy), 32'd1);
        end
        if (!seen) begin
            $display("ERROR at %0t: finish never arrived for op %s", $time, op.name());
            abort_run();
        end
        check("finish cycle", 32'(k), 32'(exp_cycles));
        check("busy", 32'(busy), 32'd0);                   // Drops with finish.
        check("rsp.error", 32'(rsp.error), 32'(err));
        check("rsp.rdata", rsp.rdata, exp_data);
        if (!err) begin
            model_store(op, addr, wdata);
        end
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check("finish", 32'(finish), 32'd0);
            check("busy", 32'(busy), 32'd0);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("busy", 32'(busy), 32'd0);
        check("finish", 32'(finish), 32'd0);
        check("rsp.error", 32'(rsp.error), 32'd0);
    endtask

    task automatic fill_memory();
        logic [31:0] a;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            a = 32'(i) << 2;
            access(OP_SW, a, {a[9:2] ^ 8'ha5, ~a[9:2], a[9:2], a[9:2] ^ 8'h3c}, 1'b0);
        end
    endtask

    task automatic test_word_access();
        logic [31:0] addrs [8];
        addrs = '{32'h0, 32'h4, 32'h3fc, 32'h100, 32'h1234, 32'hffff_fff0, 32'h2a8, 32'h7c};
        foreach (addrs[i]) access(OP_SW, addrs[i], draw_bits(32), 1'b0);
        foreach (addrs[i]) access(OP_LW, addrs[i], 32'h0, 1'b0);
        access(OP_LW, 32'h0000_0400, 32'h0, 1'b0);         // Alias of word 0.
    endtask

    task automatic test_partial_stores();
        for (int off = 0; off < 4; off++) begin
            access(OP_SW, 32'h80, 32'h1122_3344, 1'b0);
            access(OP_SB, 32'h80 + 32'(off), 32'hffff_ff00 | 32'(8'ha5 + off), 1'b0);
            access(OP_LW, 32'h80, 32'h0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(OP_SW, 32'h80, 32'h1122_3344, 1'b0);
            access(OP_SH, 32'h80 + 32'(off), 32'hdead_beef, 1'b0);
            access(OP_LW, 32'h80, 32'h0, 1'b0);
        end
    endtask

    task automatic test_load_extension();
        logic [31:0] words [2];
        words = '{32'hf08a_7f80, 32'h7f35_80c1};           // Mixed sign bits per lane.
        foreach (words[w]) begin
            access(OP_SW, 32'hc0, words[w], 1'b0);
            for (int off = 0; off < 4; off++) begin
                access(OP_LB, 32'hc0 + 32'(off), 32'h0, 1'b0);
                access(OP_LBU, 32'hc0 + 32'(off), 32'h0, 1'b0);
            end
            for (int off = 0; off < 4; off += 2) begin
                access(OP_LH, 32'hc0 + 32'(off), 32'h0, 1'b0);
                access(OP_LHU, 32'hc0 + 32'(off), 32'h0, 1'b0);
            end
        end
    endtask

    task automatic test_misalign();
        access(OP_SW, 32'h40, 32'h5566_7788, 1'b0);
        for (int off = 1; off < 4; off += 2) begin
            access(OP_LH, 32'h40 + 32'(off), 32'h0, 1'b0);
            access(OP_SH, 32'h40 + 32'(off), 32'hdead_beef, 1'b0);
        end
        for (int off = 1; off < 4; off++) begin
            access(OP_LW, 32'h40 + 32'(off), 32'h0, 1'b0);
            access(OP_SW, 32'h40 + 32'(off), 32'hdead_beef, 1'b0);
        end
        access(OP_LW, 32'h40, 32'h0, 1'b0);                // Still the first word.
    endtask

    task automatic test_ignored_req();
        access(OP_LW, 32'h40, 32'h1234_5678, 1'b1);
        quiet_cycles(6);                                   // No second finish.
        access(OP_LW, 32'h40, 32'h0, 1'b0);
    endtask

    function automatic lsu_op_e pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return OP_LB;
            3'd1:    return OP_LBU;
            3'd2:    return OP_LH;
            3'd3:    return OP_LHU;
            3'd4:    return OP_LW;
            3'd5:    return OP_SB;
            3'd6:    return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    task automatic test_random_mix();
        lsu_op_e     op;
        logic [31:0] addr;
        for (int n = 0; n < 200; n++) begin
            op   = pick_op(3'(draw_bits(3)));
            addr = draw_bits(32);                          // Full range, wraps above bit 9.
            if (draw_bits(1) != 32'h0) begin
                if (op inside {OP_LH, OP_LHU, OP_SH}) addr[0] = 1'b0;
                if (op inside {OP_LW, OP_SW}) addr[1:0] = 2'b00;
            end
            access(op, addr, draw_bits(32), 1'b0);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        lfsr     = 32'h6f48bd7e;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        fill_memory();                                     // SRAM has no reset.
        test_word_access();
        test_partial_stores();
        test_load_extension();
        test_misalign();
        test_ignored_req();
        test_random_mix();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: all.f
lsu_pkg.sv
store_align.sv
load_align.sv
data_sram.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module tb_lsu -o tb_lsu_sim

./obj_dir/tb_lsu_sim 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
